// File: logic/uart_rx_pkg.sv
package uart_rx_pkg;

	// *************************************************************************
	// Line control and receive record
	// *************************************************************************

	// Bit 7 down to bit 0, same positions as the 16550 LCR
	typedef struct packed {
		logic       dlab;
		logic       set_break;
		logic       stick_par;
		logic       even_par;
		logic       par_en;
		logic       stop_sel;
		logic [1:0] wlen;
	} lcr_t;

	// One received character with its line status
	typedef struct packed {
		logic [7:0] data;
		logic       brk;
		logic       parity_err;
		logic       framing_err;
	} rx_rec_t;

	// *************************************************************************
	// Sizes and timing constants
	// *************************************************************************

	localparam int RX_FIFO_DEPTH = 16;
	localparam int RX_FIFO_CNT_W = 5;
	localparam int RX_FIFO_PTR_W = $clog2(RX_FIFO_DEPTH);

	localparam int DIVISOR_W = 16;

	// Quiet character times before the timeout indication
	localparam int TIMEOUT_CHARS = 4;
	localparam int CHAR_TICKS_W  = 8;
	localparam int TIMEOUT_CNT_W = 10;

	// 16x ticks in one frame: start, data bits, optional parity, one stop
	function automatic logic [CHAR_TICKS_W-1:0] char_ticks(input lcr_t lcr);
		logic [3:0] bits;
		bits = 4'd7 + {2'b00, lcr.wlen} + {3'b000, lcr.par_en};
		return {bits, 4'b0000};
	endfunction

endpackage

// File: logic/baud_enable_gen.sv
`timescale 1ns/1ns

module baud_enable_gen (
	input  logic                              rvx_port_10,
	input  logic                              rvx_port_05,
	input  logic [uart_rx_pkg::DIVISOR_W-1:0] divisor,
	output logic                              tick16
);
	import uart_rx_pkg::*;

	logic [DIVISOR_W-1:0] cnt;

	// Down-counter, one tick per divisor clocks
	always_ff @(posedge rvx_port_10 or posedge rvx_port_05)
	begin
		if (rvx_port_05)
		begin
			cnt    <= '0;
			tick16 <= 1'b0;
		end
		else if (cnt == '0)
		begin
			// Divisor 0 or 1 keeps the counter parked at zero
			cnt    <= (divisor > DIVISOR_W'(1)) ? divisor - 1'b1 : '0;
			tick16 <= 1'b1;
		end
		else
		begin
			cnt    <= cnt - 1'b1;
			tick16 <= 1'b0;
		end
	end

	// With a steady divisor above 1 ticks are never back to back
	tick_spacing: assert property (@(posedge rvx_port_10) disable iff (rvx_port_05)
		(tick16 && (divisor > DIVISOR_W'(1)) && $stable(divisor)) |=> !tick16);

endmodule

// File: logic/uart_rx_deframer.sv
`timescale 1ns/1ns

module uart_rx_deframer (
	input  logic                 rvx_port_10,
	input  logic                 rvx_port_05,
	input  logic                 tick16,
	input  logic                 rxd,
	input  uart_rx_pkg::lcr_t    lcr,
	output uart_rx_pkg::rx_rec_t rec,
	output logic                 rec_push
);
	import uart_rx_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_data,
		st_parity,
		st_stop,
		st_emit
	} state_t;

	state_t                  state;
	logic [3:0]              sub_cnt;
	logic [2:0]              bit_idx;
	logic [7:0]              shreg;
	logic [7:0]              rec_data;
	logic                    par_acc;
	logic                    par_bad;
	logic                    par_err;
	logic                    frm_err;
	logic [CHAR_TICKS_W-1:0] brk_cnt;
	logic                    brk_hold;
	logic                    brk_det;
	logic                    emit_go;
	logic                    emit_q;
	logic                    mid_bit;
	logic                    last_bit;

	// Sample point of data, parity and stop bits
	assign mid_bit  = tick16 && (sub_cnt == 4'd15);
	assign last_bit = (bit_idx == (3'd4 + {1'b0, lcr.wlen}));

	// Line low for a whole character
	assign brk_det = (brk_cnt == '0) && !rxd;

	// A low stop bit waits for the line to rise or for a break
	assign emit_go = (state == st_emit) && (!frm_err || rxd || brk_det);

	// *************************************************************************
	// Frame state machine
	// *************************************************************************

	always_ff @(posedge rvx_port_10 or posedge rvx_port_05)
	begin
		if (rvx_port_05)
		begin
			state   <= st_idle;
			sub_cnt <= '0;
			bit_idx <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					sub_cnt <= '0;
					bit_idx <= '0;
					if (tick16 && !rxd && !brk_hold)
						state <= st_start;
				end
				st_start:
				begin
					if (tick16)
					begin
						if (sub_cnt == 4'd7)
						begin
							sub_cnt <= '0;
							// A start bit that is high again at mid-bit is a glitch
							state   <= rxd ? st_idle : st_data;
						end
						else
							sub_cnt <= sub_cnt + 1'b1;
					end
				end
				st_data:
				begin
					if (tick16)
						sub_cnt <= sub_cnt + 1'b1;
					if (mid_bit)
					begin
						if (last_bit)
						begin
							bit_idx <= '0;
							state   <= lcr.par_en ? st_parity : st_stop;
						end
						else
							bit_idx <= bit_idx + 1'b1;
					end
				end
				st_parity:
				begin
					if (tick16)
						sub_cnt <= sub_cnt + 1'b1;
					if (mid_bit)
						state <= st_stop;
				end
				st_stop:
				begin
					if (tick16)
						sub_cnt <= sub_cnt + 1'b1;
					if (mid_bit)
						state <= st_emit;
				end
				st_emit:
				begin
					if (emit_go)
						state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Odd, even, stick 1 (even_par low) and stick 0 (even_par high)
	always_comb
	begin
		if (lcr.stick_par)
			par_bad = (rxd == lcr.even_par);
		else if (lcr.even_par)
			par_bad = par_acc ^ rxd;
		else
			par_bad = !(par_acc ^ rxd);
	end

	// Character payload shifted in LSB first
	always_ff @(posedge rvx_port_10)
	begin
		if (state == st_start)
		begin
			par_acc <= 1'b0;
			par_err <= 1'b0;
		end
		if ((state == st_data) && mid_bit)
		begin
			shreg   <= {rxd, shreg[7:1]};
			par_acc <= par_acc ^ rxd;
		end
		if ((state == st_parity) && mid_bit)
			par_err <= par_bad;
		if ((state == st_stop) && mid_bit)
			frm_err <= !rxd;
	end

	// *************************************************************************
	// Break detection and push pulse
	// *************************************************************************

	always_ff @(posedge rvx_port_10 or posedge rvx_port_05)
	begin
		if (rvx_port_05)
		begin
			brk_cnt  <= '0;
			brk_hold <= 1'b0;
			emit_q   <= 1'b0;
		end
		else
		begin
			emit_q <= emit_go;
			if (rxd)
				brk_cnt <= char_ticks(lcr);
			else if (tick16 && (brk_cnt != '0))
				brk_cnt <= brk_cnt - 1'b1;
			// No new start until the line returns to mark after a break
			if (rxd)
				brk_hold <= 1'b0;
			else if (emit_go && brk_det)
				brk_hold <= 1'b1;
		end
	end

	// Short words sit in the top bits of the shift register
	assign rec_data = shreg >> (2'd3 - lcr.wlen);

	always_comb
	begin
		if (brk_det)
		begin
			rec.data        = 8'h00;
			rec.brk         = 1'b1;
			rec.parity_err  = 1'b0;
			rec.framing_err = 1'b1;
		end
		else
		begin
			rec.data        = rec_data;
			rec.brk         = 1'b0;
			rec.parity_err  = par_err;
			rec.framing_err = frm_err;
		end
	end

	assign rec_push = emit_go && !emit_q;

	// The FSM leaves the emit state in the cycle of the push
	push_single: assert property (@(posedge rvx_port_10) disable iff (rvx_port_05)
		emit_go |=> !emit_go);

endmodule

// File: logic/rx_fifo.sv
`timescale 1ns/1ns

module rx_fifo #(
	parameter type entry_t = uart_rx_pkg::rx_rec_t
) (
	input  logic                                  rvx_port_10,
	input  logic                                  rvx_port_05,
	input  entry_t                                wr_data,
	input  logic                                  push,
	input  logic                                  pop,
	output entry_t                                head,
	output logic [uart_rx_pkg::RX_FIFO_CNT_W-1:0] count,
	output logic                                  empty,
	output logic                                  full,
	output logic                                  overflow
);
	import uart_rx_pkg::*;

	entry_t                   mem [RX_FIFO_DEPTH];
	logic [RX_FIFO_PTR_W-1:0] wr_ptr;
	logic [RX_FIFO_PTR_W-1:0] rd_ptr;
	logic                     wr_en;
	logic                     rd_en;

	assign empty = (count == '0);
	assign full  = (count == RX_FIFO_CNT_W'(RX_FIFO_DEPTH));

	assign rd_en = pop && !empty;
	// A full FIFO still takes a push when the head leaves in the same cycle
	assign wr_en = push && (!full || rd_en);

	// Record dropped
	assign overflow = push && !wr_en;

	// Oldest entry
	assign head = mem[rd_ptr];

	always_ff @(posedge rvx_port_10)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge rvx_port_10 or posedge rvx_port_05)
	begin
		if (rvx_port_05)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count;
			endcase
		end
	end

	// The reader only pops when there is something to read
	pop_not_empty: assert property (@(posedge rvx_port_10) disable iff (rvx_port_05)
		!(pop && empty));

endmodule

// File: logic/rx_line_status.sv
`timescale 1ns/1ns

module rx_line_status (
	input  logic                                  rvx_port_10,
	input  logic                                  rvx_port_05,
	input  logic                                  tick16,
	input  uart_rx_pkg::lcr_t                     lcr,
	input  uart_rx_pkg::rx_rec_t                  head,
	input  logic [uart_rx_pkg::RX_FIFO_CNT_W-1:0] count,
	input  logic                                  empty,
	input  logic                                  overflow,
	input  logic                                  push_seen,
	input  logic                                  rd_strobe,
	output logic                                  pop,
	output logic [7:0]                            rx_data,
	output logic                                  data_ready,
	output logic                                  overrun_err,
	output logic                                  parity_err,
	output logic                                  framing_err,
	output logic                                  break_int,
	output logic                                  char_timeout
);
	import uart_rx_pkg::*;

	logic                     perr_q;
	logic                     ferr_q;
	logic                     brk_q;
	logic                     ready_nxt;
	logic [TIMEOUT_CNT_W-1:0] to_cnt;
	logic [TIMEOUT_CNT_W-1:0] to_load;

	assign pop     = rd_strobe && !empty;
	assign rx_data = head.data;

	// Next FIFO occupancy, so data_ready lines up with the count update
	assign ready_nxt = push_seen || (pop ? (count > RX_FIFO_CNT_W'(1)) : !empty);

	// *************************************************************************
	// Data ready and sticky status
	// *************************************************************************

	always_ff @(posedge rvx_port_10 or posedge rvx_port_05)
	begin
		if (rvx_port_05)
		begin
			data_ready  <= 1'b0;
			perr_q      <= 1'b0;
			ferr_q      <= 1'b0;
			brk_q       <= 1'b0;
			overrun_err <= 1'b0;
		end
		else
		begin
			data_ready <= ready_nxt;
			if (pop)
			begin
				perr_q <= 1'b0;
				ferr_q <= 1'b0;
				brk_q  <= 1'b0;
			end
			else if (!empty)
			begin
				perr_q <= perr_q | head.parity_err;
				ferr_q <= ferr_q | head.framing_err;
				brk_q  <= brk_q | head.brk;
			end
			// Overflow wins over a read in the same cycle
			if (overflow)
				overrun_err <= 1'b1;
			else if (pop)
				overrun_err <= 1'b0;
		end
	end

	// Head flags show at once, the latch holds them until the read
	assign parity_err  = perr_q | (!empty && head.parity_err);
	assign framing_err = ferr_q | (!empty && head.framing_err);
	assign break_int   = brk_q | (!empty && head.brk);

	// *************************************************************************
	// Character timeout
	// *************************************************************************

	assign to_load = TIMEOUT_CNT_W'(TIMEOUT_CHARS * char_ticks(lcr));

	always_ff @(posedge rvx_port_10 or posedge rvx_port_05)
	begin
		if (rvx_port_05)
		begin
			to_cnt       <= '0;
			char_timeout <= 1'b0;
		end
		else if (push_seen || pop)
		begin
			to_cnt       <= to_load;
			char_timeout <= 1'b0;
		end
		else if (!empty)
		begin
			if (to_cnt == '0)
				char_timeout <= 1'b1;
			else if (tick16)
				to_cnt <= to_cnt - 1'b1;
		end
	end

endmodule

// File: logic/uart_rx_top.sv
`timescale 1ns/1ns

module uart_rx_top (
	input  logic                              rvx_port_10,
	input  logic                              rvx_port_05,
	input  logic                              rxd,
	input  uart_rx_pkg::lcr_t                 lcr,
	input  logic [uart_rx_pkg::DIVISOR_W-1:0] divisor,
	input  logic                              rd_strobe,
	output logic [7:0]                        rx_data,
	output logic                              data_ready,
	output logic                              overrun_err,
	output logic                              parity_err,
	output logic                              framing_err,
	output logic                              break_int,
	output logic                              char_timeout
);
	import uart_rx_pkg::*;

	logic                     tick16;
	rx_rec_t                  rec;
	logic                     rec_push;
	rx_rec_t                  head;
	logic [RX_FIFO_CNT_W-1:0] count;
	logic                     empty;
	logic                     overflow;
	logic                     pop;

	baud_enable_gen u_baud (
		.rvx_port_10 (rvx_port_10),
		.rvx_port_05 (rvx_port_05),
		.divisor     (divisor),
		.tick16      (tick16)
	);

	uart_rx_deframer u_deframer (
		.rvx_port_10 (rvx_port_10),
		.rvx_port_05 (rvx_port_05),
		.tick16      (tick16),
		.rxd         (rxd),
		.lcr         (lcr),
		.rec         (rec),
		.rec_push    (rec_push)
	);

	rx_fifo #(
		.entry_t (rx_rec_t)
	) u_fifo (
		.rvx_port_10 (rvx_port_10),
		.rvx_port_05 (rvx_port_05),
		.wr_data     (rec),
		.push        (rec_push),
		.pop         (pop),
		.head        (head),
		.count       (count),
		.empty       (empty),
		.full        (),
		.overflow    (overflow)
	);

	rx_line_status u_status (
		.rvx_port_10  (rvx_port_10),
		.rvx_port_05  (rvx_port_05),
		.tick16       (tick16),
		.lcr          (lcr),
		.head         (head),
		.count        (count),
		.empty        (empty),
		.overflow     (overflow),
		.push_seen    (rec_push),
		.rd_strobe    (rd_strobe),
		.pop          (pop),
		.rx_data      (rx_data),
		.data_ready   (data_ready),
		.overrun_err  (overrun_err),
		.parity_err   (parity_err),
		.framing_err  (framing_err),
		.break_int    (break_int),
		.char_timeout (char_timeout)
	);

endmodule

// File: verification/uart_rx_tb.sv
`timescale 1ns/1ns

module uart_rx_tb;
	import uart_rx_pkg::*;

	localparam int CLK_HALF  = 10;
	localparam int CLK_NS    = 2 * CLK_HALF;
	localparam int MAX_CASES = 32;
	localparam int FIELDS    = 6;

	// Fault column of the cases file
	localparam int FAULT_NONE    = 0;
	localparam int FAULT_PARITY  = 1;
	localparam int FAULT_STOP    = 2;
	localparam int FAULT_BREAK   = 3;
	localparam int FAULT_BURST   = 4;
	localparam int FAULT_TIMEOUT = 5;
	localparam int CASE_END      = 15;

	logic                 rvx_port_10;
	logic                 rvx_port_05;
	logic                 rxd;
	lcr_t                 lcr;
	logic [DIVISOR_W-1:0] divisor;
	logic                 rd_strobe;
	logic [7:0]           rx_data;
	logic                 data_ready;
	logic                 overrun_err;
	logic                 parity_err;
	logic                 framing_err;
	logic                 break_int;
	logic                 char_timeout;

	logic [15:0] cases [MAX_CASES*FIELDS];
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	longint      watchdog_ns = 0;

	uart_rx_top dut (
		.rvx_port_10  (rvx_port_10),
		.rvx_port_05  (rvx_port_05),
		.rxd          (rxd),
		.lcr          (lcr),
		.divisor      (divisor),
		.rd_strobe    (rd_strobe),
		.rx_data      (rx_data),
		.data_ready   (data_ready),
		.overrun_err  (overrun_err),
		.parity_err   (parity_err),
		.framing_err  (framing_err),
		.break_int    (break_int),
		.char_timeout (char_timeout)
	);

	initial
		rvx_port_10 = 1'b0;

	always #(CLK_HALF) rvx_port_10 = !rvx_port_10;

	// *************************************************************************
	// Frame arithmetic from the 16550 rules
	// *************************************************************************

	// Start, data bits, parity if enabled, one stop
	function automatic int frame_bits(input lcr_t l);
		return 7 + int'(l.wlen) + int'(l.par_en);
	endfunction

	function automatic int bit_clocks(input int div);
		return 16 * ((div < 2) ? 1 : div);
	endfunction

	function automatic logic [7:0] word_mask(input lcr_t l);
		return 8'hff >> (3 - l.wlen);
	endfunction

	function automatic logic parity_bit(input lcr_t l, input logic [7:0] d);
		if (l.stick_par)
			return !l.even_par;
		else if (l.even_par)
			return ^d;
		else
			return ~^d;
	endfunction

	// Rough clock budget of one case for the watchdog
	function automatic longint case_clocks(input int idx);
		lcr_t l;
		int   fault;
		int   bits;
		l     = lcr_t'(cases[idx*FIELDS][7:0]);
		fault = int'(cases[idx*FIELDS+3]);
		bits  = 40;
		if (fault == FAULT_BREAK)
			bits += 2 * frame_bits(l);
		else if (fault == FAULT_BURST)
			bits += (RX_FIFO_DEPTH + 1) * (frame_bits(l) + 6);
		else if (fault == FAULT_TIMEOUT)
			bits += 6 * frame_bits(l);
		return longint'(bits * bit_clocks(int'(cases[idx*FIELDS+1]))) + 200;
	endfunction

	// *************************************************************************
	// Line driver and host reader
	// *************************************************************************

	// Starts and ends on a falling edge
	task automatic hold_line(input logic level, input int clocks);
		rxd = level;
		repeat (clocks) @(negedge rvx_port_10);
	endtask

	task automatic idle_gap(input int bc);
		hold_line(1'b1, bc * (1 + int'($urandom % 4)));
	endtask

	task automatic send_frame(input lcr_t l, input int bc, input logic [7:0] data,
		input int fault);
		int         i;
		logic [7:0] d;
		d = data & word_mask(l);
		if (fault == FAULT_BREAK)
			hold_line(1'b0, 2 * frame_bits(l) * bc);
		else
		begin
			hold_line(1'b0, bc);
			for (i = 0; i < 5 + int'(l.wlen); i++)
				hold_line(d[i], bc);
			if (l.par_en)
				hold_line(parity_bit(l, d) ^ (fault == FAULT_PARITY), bc);
			hold_line(fault != FAULT_STOP, bc);
		end
		// Back to mark for one bit
		hold_line(1'b1, bc);
	endtask

	task automatic wait_ready(input int limit, output logic seen);
		int n;
		n = 0;
		while (!data_ready && n < limit)
		begin
			@(negedge rvx_port_10);
			n++;
		end
		seen = data_ready;
	endtask

	// Outputs show the head record for the whole strobe cycle
	task automatic read_char(output logic [7:0] data, output logic [3:0] flags);
		data  = rx_data;
		flags = {overrun_err, break_int, parity_err, framing_err};
		rd_strobe = 1'b1;
		@(negedge rvx_port_10);
		rd_strobe = 1'b0;
		@(negedge rvx_port_10);
	endtask

	task automatic report_mismatch(input string what, input int got, input int expected);
		$display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
		errors++;
	endtask

	// *************************************************************************
	// One line of the cases file
	// *************************************************************************

	task automatic run_case(input int idx);
		lcr_t       l;
		int         bc;
		int         fault;
		int         char_clks;
		int         errs_before;
		int         i;
		int         elapsed;
		logic [7:0] data;
		logic [7:0] exp_data;
		logic [2:0] exp_flags;
		logic [7:0] got;
		logic [3:0] flags;
		logic       seen;

		l           = lcr_t'(cases[idx*FIELDS][7:0]);
		bc          = bit_clocks(int'(cases[idx*FIELDS+1]));
		data        = cases[idx*FIELDS+2][7:0];
		fault       = int'(cases[idx*FIELDS+3]);
		exp_data    = cases[idx*FIELDS+4][7:0];
		exp_flags   = cases[idx*FIELDS+5][2:0];
		char_clks   = frame_bits(l) * bc;
		errs_before = errors;

		lcr     = l;
		divisor = cases[idx*FIELDS+1];
		hold_line(1'b1, 2 * bc);

		if (fault == FAULT_BURST)
		begin
			// One more character than the FIFO holds so the last one is dropped
			for (i = 0; i <= RX_FIFO_DEPTH; i++)
			begin
				send_frame(l, bc, data + 8'(i), FAULT_NONE);
				idle_gap(bc);
			end
			for (i = 0; i < RX_FIFO_DEPTH; i++)
			begin
				read_char(got, flags);
				if (got !== ((exp_data + 8'(i)) & word_mask(l)))
					report_mismatch("burst rx_data", int'(got),
						int'((exp_data + 8'(i)) & word_mask(l)));
				if (flags[2:0] !== 3'b000)
					report_mismatch("burst error flags", int'(flags[2:0]), 0);
				if (i == 0 && flags[3] !== 1'b1)
					report_mismatch("overrun_err before the first read", int'(flags[3]), 1);
				if (i == 1 && flags[3] !== 1'b0)
					report_mismatch("overrun_err after the first read", int'(flags[3]), 0);
			end
			if (data_ready !== 1'b0)
				report_mismatch("data_ready after the last read", int'(data_ready), 0);
		end
		else
		begin
			send_frame(l, bc, data, fault);
			wait_ready(4 * bc, seen);
			if (!seen)
			begin
				$display("test %0d: no character came out on data_ready in time", idx);
				errors++;
			end
			else
			begin
				if (fault == FAULT_TIMEOUT)
				begin
					// Counted from one bit and a half after the push
					elapsed = 0;
					while (!char_timeout && elapsed < 6 * char_clks)
					begin
						@(negedge rvx_port_10);
						elapsed++;
					end
					if (!char_timeout)
					begin
						$display("test %0d: char_timeout stayed low for six character times",
							idx);
						errors++;
					end
					else if (elapsed < 4 * char_clks - 2 * bc ||
						elapsed > 4 * char_clks - bc)
						report_mismatch("clocks before char_timeout", elapsed,
							4 * char_clks - 3 * bc / 2);
				end
				read_char(got, flags);
				if (got !== exp_data)
					report_mismatch("rx_data", int'(got), int'(exp_data));
				if (flags[2:0] !== exp_flags)
					report_mismatch("break, parity, framing flags", int'(flags[2:0]),
						int'(exp_flags));
				if (fault == FAULT_TIMEOUT && char_timeout !== 1'b0)
					report_mismatch("char_timeout after read", int'(char_timeout), 0);
			end
		end
		idle_gap(bc);

		tests_run++;
		if (errors == errs_before)
			$display("test %0d lcr %h fault %0d: ok", idx, l, fault);
		else
		begin
			tests_failed++;
			$display("test %0d lcr %h fault %0d: %0d errors", idx, l, fault,
				errors - errs_before);
		end
	endtask

	// *************************************************************************
	// Main sequence and watchdog
	// *************************************************************************

	initial
	begin
		int     n_cases;
		int     idx;
		longint clocks;

		rvx_port_05 = 1'b1;
		rxd         = 1'b1;
		rd_strobe   = 1'b0;
		lcr         = '0;
		divisor     = DIVISOR_W'(4);
		void'($urandom(69692));

		$readmemh("verification/uart_rx_cases.txt", cases);
		n_cases = 0;
		while (n_cases < MAX_CASES && int'(cases[n_cases*FIELDS+3]) != CASE_END)
			n_cases++;
		clocks = 0;
		for (idx = 0; idx < n_cases; idx++)
			clocks += case_clocks(idx);
		watchdog_ns = 2 * clocks * CLK_NS + 20000;

		repeat (2) @(posedge rvx_port_10);
		@(negedge rvx_port_10);
		rvx_port_05 = 1'b0;

		if (n_cases == 0)
		begin
			$display("no test cases were read from the cases file");
			errors++;
		end
		for (idx = 0; idx < n_cases; idx++)
			run_case(idx);

		$display("tests %0d, passed %0d, failed %0d, failed checks %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		wait (watchdog_ns != 0);
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the run is stopped", watchdog_ns);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verification/uart_rx_cases.txt
// lcr divisor data fault exp_data exp_flags, one character test per line
// fault 0 none 1 bad parity 2 bad stop 3 break 4 overrun burst 5 timeout f end, flags {brk,par,frm}
00 0004 3c 0 1c 0
01 0002 e9 0 29 0
02 0001 d5 0 55 0
03 0003 a6 0 a6 0
07 0000 81 0 81 0
08 0004 13 0 13 0
19 0002 2d 0 2d 0
2a 0004 41 0 41 0
3b 0003 9e 0 9e 0
0b 0002 ff 0 ff 0
1b 0004 00 0 00 0
0b 0004 5a 1 5a 2
1b 0003 5a 1 5a 2
2b 0002 c3 1 c3 2
3a 0004 6e 1 6e 2
03 0004 b7 2 b7 1
08 0002 1f 2 1f 1
03 0004 55 3 00 5
1b 0002 55 3 00 5
03 0002 10 4 10 0
01 0001 30 4 30 0
03 0004 c9 5 c9 0
0b 0001 77 5 77 0
00 0000 00 f 00 0

// File: sources.f
logic/uart_rx_pkg.sv
logic/baud_enable_gen.sv
logic/uart_rx_deframer.sv
logic/rx_fifo.sv
logic/rx_line_status.sv
logic/uart_rx_top.sv
verification/uart_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the UART receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=uart_rx_tb

verilator --binary --timing --assert --top-module "$top" -Mdir obj_dir -f sources.f
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/V"$top")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1
